// ==== filelist.f ====
hdl/err_mon_pkg.sv
hdl/err_status_if.sv
hdl/fault_detect.sv
hdl/err_access_decode.sv
hdl/err_latch_bank.sv
hdl/err_readout.sv
hdl/err_monitor_top.sv
verification/err_monitor_tb.sv

// ==== hdl/err_access_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module err_access_decode import err_mon_pkg::*; #(
    parameter bus_addr_t ERR_BASE = 8'h40
) (
    input  logic        sim_clk,
    input  logic        rst_n,
    input  logic        v1,

    input  bus_addr_t   bus_addr,
    input  logic        bus_rd,
    input  logic        bus_wr,
    input  bus_data_t   bus_data_unused_guard_n,
    input  bus_data_t   bus_wdata,

    err_status_if.decode stat
);

    bus_addr_t offset;
    logic      wr_hit;
    grp_mask_t wr_mask;
    grp_mask_t pend_q;

    assign offset = bus_addr - ERR_BASE;            // wraps below base, so out of range

    assign wr_hit  = bus_wr && (offset == REG_CLEAR);
    assign wr_mask = wr_hit ? bus_wdata[N_GRP-1:0] : '0;

    // write takes the bus when both strobes are up
    assign stat.rd_hit     = bus_rd && !bus_wr && (offset <= REG_SUMMARY);
    assign stat.rd_sel     = grp_idx_t'(offset[1:0]);
    assign stat.rd_summary = (offset == REG_SUMMARY);

    // a write on a v1 edge stays pending for the following v1
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= '0;
        end else if (v1) begin
            pend_q <= wr_mask;
        end else begin
            pend_q <= pend_q | wr_mask;
        end
    end

    assign stat.clear_grp = pend_q;

    a_rd_wr_excl: assert property (@(posedge sim_clk) disable iff (!rst_n)
        !(stat.rd_hit && bus_wr));

endmodule

`default_nettype wire

// ==== hdl/err_latch_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module err_latch_bank import err_mon_pkg::*; (
    input  logic                   sim_clk,
    input  logic                   rst_n,
    input  logic                   v1,

    input  logic [EXT_FAULTS-1:0]  fault_ext,
    input  logic [FAULT_INT_W-1:0] fault_int,

    err_status_if.bank             stat
);

    err_vec_t  src;
    err_vec_t  clr_vec;
    err_vec_t  flags_q;
    err_vec_t  grp_clr [N_GRP];
    grp_mask_t summary_c;

    function automatic err_vec_t grp_bits(input int g);
        err_vec_t m;
        m = '0;
        for (int n = 0; n < N_ERR; n++) begin
            m[n] = (n >= GRP_LO[g]) && (n <= GRP_HI[g]);
        end
        return m;
    endfunction

    assign src = {fault_int, fault_ext};            // internal faults on top

    for (genvar g = 0; g < N_GRP; g++) begin : g_grp
        localparam err_vec_t MASK = grp_bits(g);

        assign grp_clr[g]   = stat.clear_grp[g] ? MASK : '0;
        assign summary_c[g] = |(flags_q & MASK);

        // only sources inside the group may survive its clear
        a_grp_cleared: assert property (@(posedge sim_clk) disable iff (!rst_n)
            (v1 && stat.clear_grp[g] && ((src & MASK) == '0))
            |=> ((stat.flags & MASK) == '0));
    end

    always_comb begin
        clr_vec = '0;
        for (int g = 0; g < N_GRP; g++) begin
            clr_vec = clr_vec | grp_clr[g];
        end
    end

    // set beats clear, nothing moves between strobes
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (v1) begin
            flags_q <= src | (flags_q & ~clr_vec);
        end
    end

    assign stat.flags   = flags_q;
    assign stat.summary = summary_c;

endmodule

`default_nettype wire

// ==== hdl/err_mon_pkg.sv ====
package err_mon_pkg;

    localparam int N_ERR = 26;                      // sticky latches in the bank
    localparam int N_GRP = 4;
    localparam int GRP_W = 8;                       // readout word per group

    typedef logic [N_ERR-1:0] err_vec_t;            // bit n is error n+1
    typedef logic [GRP_W-1:0] grp_word_t;
    typedef logic [N_GRP-1:0] grp_mask_t;
    typedef logic [1:0]       grp_idx_t;
    typedef logic [7:0]       bus_addr_t;
    typedef logic [7:0]       bus_data_t;

    // group bounds as bit positions in err_vec_t (error number minus one)
    localparam int GRP_LO [N_GRP] = '{0, 7, 13, 20};
    localparam int GRP_HI [N_GRP] = '{6, 12, 19, 25};

    // internal fault sources sit above the external ones
    localparam int EXT_FAULTS  = 23;                // bits 0..22
    localparam int FAULT_MEM_A = 23;                // error 24
    localparam int FAULT_MEM_B = 24;                // error 25
    localparam int FAULT_XFER  = 25;                // error 26
    localparam int FAULT_INT_W = N_ERR - EXT_FAULTS;

    // register offsets from ERR_BASE
    localparam bus_addr_t REG_SUMMARY = 8'h04;      // groups live at 0..3
    localparam bus_addr_t REG_CLEAR   = 8'h05;

endpackage

// ==== hdl/err_monitor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module err_monitor_top import err_mon_pkg::*; #(
    parameter int        WORD_W       = 16,
    parameter int        XFER_TIMEOUT = 64,
    parameter bus_addr_t ERR_BASE     = 8'h40
) (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    input  logic                  v1,

    input  logic [EXT_FAULTS-1:0] fault_ext,

    input  logic [WORD_W-1:0]     mem_a_word,
    input  logic                  mem_a_check,
    input  logic                  mem_a_valid,
    input  logic [WORD_W-1:0]     mem_b_word,
    input  logic                  mem_b_check,
    input  logic                  mem_b_valid,

    input  logic                  xfer_start,
    input  logic                  xfer_done,

    input  bus_addr_t             bus_addr,
    input  logic                  bus_rd,
    input  logic                  bus_wr,
    input  bus_data_t             bus_wdata,

    output bus_data_t             rd_data,
    output logic                  rd_valid,
    output grp_mask_t             err_summary
);

    logic [FAULT_INT_W-1:0] fault_int;

    err_status_if stat ();

    fault_detect #(
        .WORD_W       (WORD_W),
        .XFER_TIMEOUT (XFER_TIMEOUT)
    ) u_fault_detect (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .v1          (v1),
        .mem_a_word  (mem_a_word),
        .mem_a_check (mem_a_check),
        .mem_a_valid (mem_a_valid),
        .mem_b_word  (mem_b_word),
        .mem_b_check (mem_b_check),
        .mem_b_valid (mem_b_valid),
        .xfer_start  (xfer_start),
        .xfer_done   (xfer_done),
        .fault_int   (fault_int)
    );

    err_access_decode #(
        .ERR_BASE (ERR_BASE)
    ) u_decode (
        .sim_clk                 (sim_clk),
        .rst_n                   (rst_n),
        .v1                      (v1),
        .bus_addr                (bus_addr),
        .bus_rd                  (bus_rd),
        .bus_wr                  (bus_wr),
        .bus_data_unused_guard_n (bus_wdata),
        .bus_wdata               (bus_wdata),
        .stat                    (stat)
    );

    err_latch_bank u_bank (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .v1        (v1),
        .fault_ext (fault_ext),
        .fault_int (fault_int),
        .stat      (stat)
    );

    err_readout u_readout (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .stat     (stat),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    assign err_summary = stat.summary;

endmodule

`default_nettype wire

// ==== hdl/err_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module err_readout import err_mon_pkg::*; (
    input  logic         sim_clk,
    input  logic         rst_n,

    err_status_if.readout stat,

    output bus_data_t    rd_data,
    output logic         rd_valid
);

    err_vec_t  shifted;
    grp_word_t grp_word;
    bus_data_t rd_next;

    function automatic grp_word_t width_mask(input grp_idx_t g);
        grp_word_t m;
        m = '0;
        for (int b = 0; b < GRP_W; b++) begin
            m[b] = (b <= (GRP_HI[g] - GRP_LO[g]));
        end
        return m;
    endfunction

    // right-align the group, drop its neighbours
    always_comb begin
        shifted  = stat.flags >> GRP_LO[stat.rd_sel];
        grp_word = shifted[GRP_W-1:0] & width_mask(stat.rd_sel);
    end

    assign rd_next = stat.rd_summary ? bus_data_t'(stat.summary) : bus_data_t'(grp_word);

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= stat.rd_hit;                // one pulse per accepted read
            if (stat.rd_hit) begin
                rd_data <= rd_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/err_status_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface err_status_if import err_mon_pkg::*; ();

    err_vec_t  flags;                               // latch contents
    grp_mask_t summary;                             // per-group OR
    grp_mask_t clear_grp;                           // pending clears, retired on v1
    logic      rd_hit;
    grp_idx_t  rd_sel;
    logic      rd_summary;                          // summary word instead of a group

    modport bank (
        output flags,
        output summary,
        input  clear_grp
    );

    modport decode (
        output clear_grp,
        output rd_hit,
        output rd_sel,
        output rd_summary
    );

    modport readout (
        input flags,
        input summary,
        input rd_hit,
        input rd_sel,
        input rd_summary
    );

endinterface

`default_nettype wire

// ==== hdl/fault_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module fault_detect import err_mon_pkg::*; #(
    parameter int WORD_W       = 16,
    parameter int XFER_TIMEOUT = 64
) (
    input  logic                   sim_clk,
    input  logic                   rst_n,
    input  logic                   v1,

    input  logic [WORD_W-1:0]      mem_a_word,
    input  logic                   mem_a_check,
    input  logic                   mem_a_valid,
    input  logic [WORD_W-1:0]      mem_b_word,
    input  logic                   mem_b_check,
    input  logic                   mem_b_valid,

    input  logic                   xfer_start,
    input  logic                   xfer_done,

    output logic [FAULT_INT_W-1:0] fault_int
);

    localparam int IDX_A = FAULT_MEM_A - EXT_FAULTS;
    localparam int IDX_B = FAULT_MEM_B - EXT_FAULTS;
    localparam int IDX_X = FAULT_XFER - EXT_FAULTS;
    localparam int CNT_W = $clog2(XFER_TIMEOUT + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(XFER_TIMEOUT - 1);

    logic                   par_a_bad;
    logic                   par_b_bad;
    logic                   xfer_active;
    logic [CNT_W-1:0]       xfer_cnt;
    logic                   xfer_to;
    logic [FAULT_INT_W-1:0] det;
    logic [FAULT_INT_W-1:0] hold_q;

    // even parity over word and check bit
    assign par_a_bad = mem_a_valid && ((^mem_a_word) != mem_a_check);
    assign par_b_bad = mem_b_valid && ((^mem_b_word) != mem_b_check);

    // last counted cycle with no done and no restart
    assign xfer_to = xfer_active && !xfer_start && !xfer_done && (xfer_cnt == CNT_LAST);

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer_active <= 1'b0;
            xfer_cnt    <= '0;
        end else if (xfer_start) begin
            xfer_active <= 1'b1;                    // restarts an open transfer too
            xfer_cnt    <= '0;
        end else if (xfer_done || xfer_to) begin
            xfer_active <= 1'b0;                    // idle until next start
            xfer_cnt    <= '0;
        end else if (xfer_active) begin
            xfer_cnt <= xfer_cnt + 1'b1;
        end
    end

    always_comb begin
        det        = '0;
        det[IDX_A] = par_a_bad;
        det[IDX_B] = par_b_bad;
        det[IDX_X] = xfer_to;
    end

    // new detection wins over the v1 that consumes the old one
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= '0;
        end else begin
            hold_q <= det | (v1 ? '0 : hold_q);
        end
    end

    assign fault_int = hold_q;

    a_cnt_idle: assert property (@(posedge sim_clk) disable iff (!rst_n)
        !xfer_active |-> (xfer_cnt == '0));

endmodule

`default_nettype wire

// ==== verification/err_monitor_tb.sv ====
`timescale 1ns/1ps

module err_monitor_tb import err_mon_pkg::*; ();

    localparam int        WORD_W       = 16;
    localparam int        XFER_TIMEOUT = 64;
    localparam bus_addr_t ERR_BASE     = 8'h40;
    localparam int        CLK_PERIOD   = 10;
    localparam int        RST_CYCLES   = 10;
    localparam int        N_TESTS      = 6;
    localparam int        RUN_CYCLES   = RST_CYCLES + N_TESTS * (XFER_TIMEOUT + 40);

    logic                  sim_clk;
    logic                  rst_n;
    logic                  v1;
    logic [EXT_FAULTS-1:0] fault_ext;
    logic [WORD_W-1:0]     mem_a_word;
    logic                  mem_a_check;
    logic                  mem_a_valid;
    logic [WORD_W-1:0]     mem_b_word;
    logic                  mem_b_check;
    logic                  mem_b_valid;
    logic                  xfer_start;
    logic                  xfer_done;
    bus_addr_t             bus_addr;
    logic                  bus_rd;
    logic                  bus_wr;
    bus_data_t             bus_wdata;
    bus_data_t             rd_data;
    logic                  rd_valid;
    grp_mask_t             err_summary;

    integer    seed;
    logic [1:0] phase;
    logic      rd_accept;
    logic      wr_accept;
    err_vec_t  exp_flags;                           // reference latch contents
    grp_mask_t exp_pend;
    logic      hold_a;
    logic      hold_b;
    logic      hold_x;
    logic      xfer_open;
    int        xfer_len;
    bus_data_t exp_rd_data;

    err_monitor_top #(
        .WORD_W       (WORD_W),
        .XFER_TIMEOUT (XFER_TIMEOUT),
        .ERR_BASE     (ERR_BASE)
    ) dut0 (.*);

    function automatic grp_mask_t summary_of(input err_vec_t f);
        grp_mask_t s;
        s = '0;
        for (int g = 0; g < N_GRP; g++) begin
            for (int n = GRP_LO[g]; n <= GRP_HI[g]; n++) begin
                s[g] = s[g] | f[n];
            end
        end
        return s;
    endfunction

    function automatic bus_data_t group_word_of(input err_vec_t f, input int g);
        bus_data_t w;
        w = '0;
        for (int n = GRP_LO[g]; n <= GRP_HI[g]; n++) begin
            w[n - GRP_LO[g]] = f[n];
        end
        return w;
    endfunction

    function automatic err_vec_t clear_bits_of(input grp_mask_t m);
        err_vec_t c;
        c = '0;
        for (int g = 0; g < N_GRP; g++) begin
            for (int n = GRP_LO[g]; n <= GRP_HI[g]; n++) begin
                c[n] = c[n] | m[g];
            end
        end
        return c;
    endfunction

    function automatic bus_data_t expected_read(input err_vec_t f, input bus_addr_t addr);
        bus_addr_t offs;
        offs = addr - ERR_BASE;
        if (offs == 8'd4) begin
            return {4'b0000, summary_of(f)};
        end else begin
            return group_word_of(f, offs[1:0]);
        end
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "testbench check failed");
    endtask

    assign rd_accept = bus_rd && !bus_wr && (bus_addr >= ERR_BASE) &&
                       (bus_addr <= ERR_BASE + 8'd4);
    assign wr_accept = bus_wr && (bus_addr == ERR_BASE + 8'd5);

    initial begin
        sim_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sim_clk = ~sim_clk;
    end

    // v1 strobe in one cycle of four
    always @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
            v1    <= 1'b0;
        end else begin
            phase <= phase + 2'd1;
            v1    <= (phase == 2'd3);
        end
    end

    // reference model on pre-edge inputs
    always @(posedge sim_clk or negedge rst_n) begin
        logic      det_a;
        logic      det_b;
        logic      det_x;
        grp_mask_t wr_mask;
        err_vec_t  src;
        if (!rst_n) begin
            exp_flags   <= '0;
            exp_pend    <= '0;
            hold_a      <= 1'b0;
            hold_b      <= 1'b0;
            hold_x      <= 1'b0;
            xfer_open   <= 1'b0;
            xfer_len    <= 0;
            exp_rd_data <= '0;
        end else begin
            det_a   = mem_a_valid && (^{mem_a_word, mem_a_check});
            det_b   = mem_b_valid && (^{mem_b_word, mem_b_check});
            det_x   = 1'b0;
            wr_mask = wr_accept ? bus_wdata[3:0] : 4'b0000;
            src     = {hold_x, hold_b, hold_a, fault_ext};
            if (xfer_start) begin
                xfer_open <= 1'b1;
                xfer_len  <= 1;
            end else if (xfer_open) begin
                if (xfer_done) begin
                    xfer_open <= 1'b0;
                end else if (xfer_len == XFER_TIMEOUT) begin
                    xfer_open <= 1'b0;              // timed out
                    det_x = 1'b1;
                end else begin
                    xfer_len <= xfer_len + 1;
                end
            end
            hold_a <= det_a | (hold_a & !v1);
            hold_b <= det_b | (hold_b & !v1);
            hold_x <= det_x | (hold_x & !v1);
            if (v1) begin
                exp_flags <= src | (exp_flags & ~clear_bits_of(exp_pend));
                exp_pend  <= wr_mask;
            end else begin
                exp_pend <= exp_pend | wr_mask;
            end
            if (rd_accept) begin
                exp_rd_data <= expected_read(exp_flags, bus_addr);
            end
        end
    end

    a_summary: assert property (@(posedge sim_clk) disable iff (!rst_n)
        err_summary == summary_of(exp_flags))
        else report_failure($sformatf("mismatch at %0t: err_summary got %h expected %h",
            $time, $sampled(err_summary), summary_of($sampled(exp_flags))));

    a_rd_valid: assert property (@(posedge sim_clk) disable iff (!rst_n)
        rd_accept |=> rd_valid)
        else report_failure($sformatf("mismatch at %0t: rd_valid got %b expected 1",
            $time, $sampled(rd_valid)));

    a_rd_data: assert property (@(posedge sim_clk) disable iff (!rst_n)
        rd_accept |=> (rd_data == exp_rd_data))
        else report_failure($sformatf("mismatch at %0t: rd_data got %h expected %h",
            $time, $sampled(rd_data), $sampled(exp_rd_data)));

    a_rd_quiet: assert property (@(posedge sim_clk) disable iff (!rst_n)
        !rd_accept |=> !rd_valid)
        else report_failure($sformatf("mismatch at %0t: rd_valid got %b expected 0",
            $time, $sampled(rd_valid)));

    task automatic wait_v1_edge();
        do begin
            @(posedge sim_clk);
        end while (v1 !== 1'b1);
    endtask

    task automatic bus_read(input bus_addr_t offs);
        bus_addr <= ERR_BASE + offs;
        bus_rd   <= 1'b1;
        @(posedge sim_clk);
        bus_rd <= 1'b0;
        @(posedge sim_clk);
    endtask

    task automatic bus_write(input grp_mask_t mask);
        bus_addr  <= ERR_BASE + 8'd5;
        bus_wdata <= {4'b0000, mask};
        bus_wr    <= 1'b1;
        @(posedge sim_clk);
        bus_wr <= 1'b0;
    endtask

    task automatic bus_collide(input bus_addr_t offs);
        bus_addr <= ERR_BASE + offs;                // write wins over the read
        bus_rd   <= 1'b1;
        bus_wr   <= 1'b1;
        @(posedge sim_clk);
        bus_rd <= 1'b0;
        bus_wr <= 1'b0;
        @(posedge sim_clk);
    endtask

    task automatic mem_access(input logic port_b, input logic bad);
        logic [WORD_W-1:0] word;
        word = $random(seed);
        if (port_b) begin
            mem_b_word  <= word;
            mem_b_check <= (^word) ^ bad;
            mem_b_valid <= 1'b1;
        end else begin
            mem_a_word  <= word;
            mem_a_check <= (^word) ^ bad;
            mem_a_valid <= 1'b1;
        end
        @(posedge sim_clk);
        mem_a_valid <= 1'b0;
        mem_b_valid <= 1'b0;
        wait_v1_edge();
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog: run still busy after %0d cycles, stimulus or DUT hung", RUN_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed        = 32'hbbb800ea;
        rst_n       = 1'b0;
        v1          = 1'b0;
        fault_ext   = '0;
        mem_a_word  = '0;
        mem_a_check = 1'b0;
        mem_a_valid = 1'b0;
        mem_b_word  = '0;
        mem_b_check = 1'b0;
        mem_b_valid = 1'b0;
        xfer_start  = 1'b0;
        xfer_done   = 1'b0;
        bus_addr    = '0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        bus_wdata   = '0;
        repeat (RST_CYCLES) @(posedge sim_clk);
        rst_n <= 1'b1;

        for (int a = 0; a <= 4; a++) begin         // all reads zero after reset
            bus_read(bus_addr_t'(a));
        end
        bus_read(8'd6);

        wait_v1_edge();
        fault_ext[3] <= 1'b1;                       // pulse between strobes
        @(posedge sim_clk);
        fault_ext <= '0;
        bus_read(8'd0);
        fault_ext[3] <= 1'b1;
        wait_v1_edge();
        fault_ext <= '0;
        bus_read(8'd0);
        wait_v1_edge();
        bus_read(8'd0);

        fault_ext <= (23'd1 << 8) | (23'd1 << 10) | (23'd1 << 15);
        wait_v1_edge();
        fault_ext <= 23'd1 << 10;                   // keep one group 1 source up
        bus_write(4'b0010);
        bus_read(8'd1);
        bus_collide(8'd1);
        wait_v1_edge();
        fault_ext <= '0;
        bus_read(8'd1);
        bus_read(8'd2);
        bus_read(8'd4);

        mem_access(1'b0, 1'b1);
        bus_read(8'd3);
        mem_access(1'b0, 1'b0);
        mem_access(1'b1, 1'b1);
        mem_access(1'b1, 1'b0);
        bus_read(8'd3);

        bus_write(4'b1000);
        wait_v1_edge();
        xfer_start <= 1'b1;
        @(posedge sim_clk);
        xfer_start <= 1'b0;
        repeat (XFER_TIMEOUT / 2) @(posedge sim_clk);
        xfer_done <= 1'b1;
        @(posedge sim_clk);
        xfer_done <= 1'b0;
        wait_v1_edge();
        bus_read(8'd3);
        xfer_start <= 1'b1;                         // left open this time
        @(posedge sim_clk);
        xfer_start <= 1'b0;
        repeat (XFER_TIMEOUT + 4) @(posedge sim_clk);
        wait_v1_edge();
        bus_read(8'd3);
        bus_read(8'd4);

        for (int i = 0; i < 16; i++) begin
            fault_ext <= $random(seed) & $random(seed) & $random(seed);
            wait_v1_edge();
            fault_ext <= '0;
            bus_read(8'd4);
            bus_write(grp_mask_t'($random(seed)));
            bus_read(bus_addr_t'($random(seed) & 3));
        end
        wait_v1_edge();
        bus_read(8'd4);
        @(posedge sim_clk);                         // last read checked before this edge

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
